// ==== sources.f ====
+incdir+include
rtl/systolic_pkg.sv
rtl/mac_pe.sv
rtl/pe_array.sv
rtl/operand_feeder.sv
rtl/result_drain.sv
rtl/matmul_4x4_systolic.sv
testbench/matmul_asserts.sv
testbench/matmul_tb.sv

// ==== Bender.yml ====
package:
  name: matmul_4x4_systolic

sources:
  - include_dirs:
      - include
    files:
      - rtl/systolic_pkg.sv
      - rtl/mac_pe.sv
      - rtl/pe_array.sv
      - rtl/operand_feeder.sv
      - rtl/result_drain.sv
      - rtl/matmul_4x4_systolic.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/matmul_asserts.sv
      - testbench/matmul_tb.sv

// ==== testbench/matmul_tb.sv ====
////////////////////////////////////////
// Each table row is one multiply; memories answer one cycle after the address
////////////////////////////////////////
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module matmul_tb;
    import systolic_pkg::*;

    localparam int NUM_ROWS       = 6;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40;
    localparam int MEM_WORDS      = 1 << `AWIDTH;

    // One multiply: operand placement, the three masks and the fill mode
    typedef struct packed {
        operand_cfg_t cfg_a;
        operand_cfg_t cfg_b;
        operand_cfg_t cfg_c;
        mask_t        row_mask;
        mask_t        inner_mask;
        mask_t        col_mask;
        logic         random_fill;
    } test_row_t;

    logic         clk;
    logic         reset;
    logic         pe_reset;
    logic         start_mat_mul;
    operand_cfg_t cfg_a;
    operand_cfg_t cfg_b;
    operand_cfg_t cfg_c;
    mask_t        validity_mask_a_rows;
    mask_t        validity_mask_a_cols_b_rows;
    mask_t        validity_mask_b_cols;
    lanes_t       a_data;
    lanes_t       b_data;
    addr_t        a_addr;
    addr_t        b_addr;
    addr_t        c_addr;
    lanes_t       c_data_out;
    logic         c_data_available;
    logic         done_mat_mul;

    lanes_t    a_mem [MEM_WORDS];
    lanes_t    b_mem [MEM_WORDS];
    elem_t     mat_a [`MAT_SIZE][`MAT_SIZE];
    elem_t     mat_b [`MAT_SIZE][`MAT_SIZE];
    elem_t     exp_c [`MAT_SIZE][`MAT_SIZE];
    test_row_t test_table [NUM_ROWS];
    integer    seed;
    int        cycle_cnt;

    matmul_4x4_systolic dut_i (.*);

    bind matmul_4x4_systolic matmul_asserts asserts_i (.*);

    always #2 clk = ~clk;

    // Memory models with one cycle of read latency
    always @(posedge clk)
    begin
        a_data <= #1 a_mem[a_addr];
        b_data <= #1 b_mem[b_addr];
    end

    // Watchdog for hangs and for failures of the bound assertions
    always @(negedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (dut_i.asserts_i.failures != 0)
        begin
            $display("A protocol assertion on the DUT failed at %0t", $time);
            stop_on_failure();
        end
        else if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("The run hung: no completion within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Address of step k of a strided region, wrapping at the address width
    function automatic addr_t step_addr(input operand_cfg_t cfg, input int k);
        return addr_t'(int'(cfg.base) + k * int'(cfg.stride));
    endfunction

    function automatic operand_cfg_t make_cfg(input addr_t base, input stride_t stride);
        operand_cfg_t cfg;
        cfg.base   = base;
        cfg.stride = stride;
        return cfg;
    endfunction

    function automatic test_row_t make_row(input operand_cfg_t ca, input operand_cfg_t cb,
                                           input operand_cfg_t cc, input mask_t rows,
                                           input mask_t inner, input mask_t cols,
                                           input logic random_fill);
        test_row_t row;
        row.cfg_a       = ca;
        row.cfg_b       = cb;
        row.cfg_c       = cc;
        row.row_mask    = rows;
        row.inner_mask  = inner;
        row.col_mask    = cols;
        row.random_fill = random_fill;
        return row;
    endfunction

    // Background words mix every address bit, so a stray read is visible
    function automatic lanes_t background_word(input addr_t addr, input elem_t salt);
        lanes_t word;
        for (int l = 0; l < `MAT_SIZE; l++)
            word[l] = elem_t'(addr) ^ elem_t'(addr >> 2) ^ elem_t'(8'h5a + l * 49) ^ salt;
        return word;
    endfunction

    task automatic fill_matrices(input logic random_fill);
        for (int i = 0; i < `MAT_SIZE; i++)
            for (int k = 0; k < `MAT_SIZE; k++)
            begin
                if (random_fill)
                begin
                    mat_a[i][k] = elem_t'($random(seed));
                    mat_b[i][k] = elem_t'($random(seed));
                end
                else
                begin
                    mat_a[i][k] = elem_t'(4 * i + k + 1);
                    mat_b[i][k] = elem_t'(37 * (i + 1) + 5 * k);
                end
            end
    endtask

    // Column k of A and row k of B sit at step k of their regions
    task automatic load_memories(input operand_cfg_t ca, input operand_cfg_t cb);
        lanes_t word;
        for (int k = 0; k < `MAT_SIZE; k++)
        begin
            for (int i = 0; i < `MAT_SIZE; i++)
                word[i] = mat_a[i][k];
            a_mem[step_addr(ca, k)] = word;
            for (int j = 0; j < `MAT_SIZE; j++)
                word[j] = mat_b[k][j];
            b_mem[step_addr(cb, k)] = word;
        end
    endtask

    // Masked rows, columns and inner steps drop out; sums wrap modulo 256
    task automatic compute_reference(input mask_t rows, input mask_t inner, input mask_t cols);
        elem_t sum;
        for (int i = 0; i < `MAT_SIZE; i++)
            for (int j = 0; j < `MAT_SIZE; j++)
            begin
                sum = '0;
                if (rows[i] && cols[j])
                    for (int k = 0; k < `MAT_SIZE; k++)
                        if (inner[k])
                            sum = sum + elem_t'(mat_a[i][k] * mat_b[k][j]);
                exp_c[i][j] = sum;
            end
    endtask

    ////////////////////////////////////////
    // One multiply from the table
    ////////////////////////////////////////

    task automatic run_row(input int r);
        test_row_t row;
        int        n;
        int        k;
        int        cols;
        int        dones;
        row = test_table[r];
        fill_matrices(row.random_fill);
        load_memories(row.cfg_a, row.cfg_b);
        compute_reference(row.row_mask, row.inner_mask, row.col_mask);

        cfg_a                       = row.cfg_a;
        cfg_b                       = row.cfg_b;
        cfg_c                       = row.cfg_c;
        validity_mask_a_rows        = row.row_mask;
        validity_mask_a_cols_b_rows = row.inner_mask;
        validity_mask_b_cols        = row.col_mask;
        pe_reset                    = 1'b1;
        next_cycle();
        pe_reset = 1'b0;
        repeat (2) next_cycle();

        // n follows the run count, 0 in the cycle where start rises
        start_mat_mul = 1'b1;
        n     = 0;
        cols  = 0;
        dones = 0;
        while (dones == 0)
        begin
            @(negedge clk);
            if (n <= `MAT_SIZE + 1)
            begin
                k = (n >= 1 && n <= `MAT_SIZE) ? n - 1 : -1;
                check_value("a_addr", a_addr, step_addr(row.cfg_a, k));
                check_value("b_addr", b_addr, step_addr(row.cfg_b, k));
            end
            if (c_data_available)
            begin
                if (cols >= `MAT_SIZE)
                begin
                    $display("c_data_available stayed high for more than %0d cycles",
                             `MAT_SIZE);
                    stop_on_failure();
                end
                check_value($sformatf("c_addr for column %0d", cols), c_addr,
                            step_addr(row.cfg_c, cols));
                for (int i = 0; i < `MAT_SIZE; i++)
                    check_value($sformatf("c_data_out column %0d lane %0d", cols, i),
                                c_data_out[i], exp_c[i][cols]);
                cols++;
            end
            if (done_mat_mul)
            begin
                dones++;
                check_value("columns delivered by done_mat_mul", cols, `MAT_SIZE);
            end
            n++;
        end

        @(negedge clk);
        check_value("done_mat_mul after its pulse", done_mat_mul, 1'b0);
        check_value("c_data_available after the last column", c_data_available, 1'b0);
        next_cycle();
        start_mat_mul = 1'b0;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        clk                         = 1'b0;
        reset                       = 1'b1;
        pe_reset                    = 1'b0;
        start_mat_mul               = 1'b0;
        cfg_a                       = '0;
        cfg_b                       = '0;
        cfg_c                       = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        a_data                      = '0;
        b_data                      = '0;
        cycle_cnt                   = 0;
        seed                        = 32'h365b_8389;

        for (int a = 0; a < MEM_WORDS; a++)
        begin
            a_mem[a] = background_word(addr_t'(a), 8'h00);
            b_mem[a] = background_word(addr_t'(a), 8'hff);
        end

        // Cfg order is A, B, C, then row, inner and column masks, then random fill
        test_table[0] = make_row(make_cfg(10'h010, 8'h01), make_cfg(10'h100, 8'h02),
                                 make_cfg(10'h200, 8'h04), 4'b1111, 4'b1111, 4'b1111, 1'b0);
        test_table[1] = make_row(make_cfg(10'h080, 8'h10), make_cfg(10'h300, 8'h03),
                                 make_cfg(10'h3f0, 8'h08), 4'b1111, 4'b1111, 4'b1111, 1'b1);
        test_table[2] = make_row(make_cfg(10'h020, 8'h05), make_cfg(10'h140, 8'h01),
                                 make_cfg(10'h220, 8'h01), 4'b1010, 4'b1111, 4'b0110, 1'b0);
        test_table[3] = make_row(make_cfg(10'h005, 8'h20), make_cfg(10'h3c0, 8'h11),
                                 make_cfg(10'h000, 8'h40), 4'b1111, 4'b1001, 4'b1111, 1'b1);
        test_table[4] = make_row(make_cfg(10'h1f0, 8'h07), make_cfg(10'h001, 8'hff),
                                 make_cfg(10'h2a0, 8'h02), 4'b0111, 4'b0110, 4'b1101, 1'b1);
        test_table[5] = make_row(make_cfg(10'h010, 8'h01), make_cfg(10'h100, 8'h02),
                                 make_cfg(10'h200, 8'h04), 4'b1111, 4'b1111, 4'b1111, 1'b1);

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        repeat (3) next_cycle();

        if (dut_i.asserts_i.failures == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("A protocol assertion on the DUT failed during the run");
            stop_on_failure();
        end
    end

endmodule

// ==== testbench/matmul_asserts.sv ====
////////////////////////////////////////
// Bound to matmul_4x4_systolic; checks the run protocol, not the data
////////////////////////////////////////
`timescale 1ns/1ps

module matmul_asserts (
    input logic                       clk,
    input logic                       reset,
    input logic                       start_mat_mul,
    input logic                       done_mat_mul,
    input logic                       c_data_available,
    input systolic_pkg::addr_t        c_addr,
    input systolic_pkg::operand_cfg_t cfg_c
);
    import systolic_pkg::*;

    // Failed assertions so far
    int failures = 0;

    done_single_pulse : assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul)
    else
    begin
        $error("done_mat_mul was high on two consecutive cycles");
        failures++;
    end

    avail_needs_start : assert property (@(posedge clk) disable iff (reset)
        c_data_available |-> start_mat_mul)
    else
    begin
        $error("c_data_available was high while start_mat_mul was low");
        failures++;
    end

    // Consecutive C columns land one C stride apart
    c_addr_stride : assert property (@(posedge clk) disable iff (reset)
        c_data_available ##1 c_data_available
            |-> c_addr == addr_t'($past(c_addr) + cfg_c.stride))
    else
    begin
        $error("c_addr did not advance by the C stride");
        failures++;
    end

endmodule

// ==== rtl/matmul_4x4_systolic.sv ====
////////////////////////////////////////
// start_mat_mul is held high for the run; pulse pe_reset and drop start between runs
////////////////////////////////////////
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module matmul_4x4_systolic (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pe_reset,
    input  logic                       start_mat_mul,
    input  systolic_pkg::operand_cfg_t cfg_a,
    input  systolic_pkg::operand_cfg_t cfg_b,
    input  systolic_pkg::operand_cfg_t cfg_c,
    input  systolic_pkg::mask_t        validity_mask_a_rows,
    input  systolic_pkg::mask_t        validity_mask_a_cols_b_rows,
    input  systolic_pkg::mask_t        validity_mask_b_cols,
    input  systolic_pkg::lanes_t       a_data,
    input  systolic_pkg::lanes_t       b_data,
    output systolic_pkg::addr_t        a_addr,
    output systolic_pkg::addr_t        b_addr,
    output systolic_pkg::addr_t        c_addr,
    output systolic_pkg::lanes_t       c_data_out,
    output logic                       c_data_available,
    output logic                       done_mat_mul
);
    import systolic_pkg::*;

    // Done is registered here, so it shows in the count after DONE_CNT,
    // together with the last C column
    localparam int DONE_CNT = 3 * `MAT_SIZE - 1 + 2 * `NUM_CYCLES_IN_MAC;

    cnt_t   clk_cnt;
    lanes_t a_skewed;
    lanes_t b_skewed;
    grid_t  results;

    ////////////////////////////////////////
    // Run counter and done pulse
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt      <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            clk_cnt      <= clk_cnt + 1'b1;
            done_mat_mul <= (clk_cnt == cnt_t'(DONE_CNT));
        end
    end

    // A streams columns into the west edge, B streams rows into the north edge
    operand_feeder feed_a (
        .clk(clk), .reset(reset), .start_mat_mul(start_mat_mul), .clk_cnt(clk_cnt),
        .cfg(cfg_a), .lane_mask(validity_mask_a_rows),
        .step_mask(validity_mask_a_cols_b_rows),
        .mem_data(a_data), .mem_addr(a_addr), .skewed(a_skewed)
    );

    operand_feeder feed_b (
        .clk(clk), .reset(reset), .start_mat_mul(start_mat_mul), .clk_cnt(clk_cnt),
        .cfg(cfg_b), .lane_mask(validity_mask_b_cols),
        .step_mask(validity_mask_a_cols_b_rows),
        .mem_data(b_data), .mem_addr(b_addr), .skewed(b_skewed)
    );

    pe_array mesh_i (
        .clk(clk), .reset(reset), .pe_reset(pe_reset),
        .a_edge(a_skewed), .b_edge(b_skewed), .results(results)
    );

    result_drain drain_i (
        .clk(clk), .reset(reset), .start_mat_mul(start_mat_mul), .clk_cnt(clk_cnt),
        .cfg_c(cfg_c), .results(results), .c_addr(c_addr),
        .c_data_out(c_data_out), .c_data_available(c_data_available)
    );

endmodule

// ==== rtl/result_drain.sv ====
////////////////////////////////////////
// Streams one C column per cycle with no back-pressure from the sink
////////////////////////////////////////
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module result_drain (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_mat_mul,
    input  systolic_pkg::cnt_t         clk_cnt,
    input  systolic_pkg::operand_cfg_t cfg_c,
    input  systolic_pkg::grid_t        results,
    output systolic_pkg::addr_t        c_addr,
    output systolic_pkg::lanes_t       c_data_out,
    output logic                       c_data_available
);
    import systolic_pkg::*;

    // The last product reaches PE (3,3) in this count
    localparam int LATCH_CNT = 3 * `MAT_SIZE - 1 + `NUM_CYCLES_IN_MAC;
    localparam int CNT_BITS  = `LOG2_MAT_SIZE + 1;

    logic                latch_en;
    logic [CNT_BITS-1:0] cols_left;
    lanes_t              col_sr [`MAT_SIZE];

    assign latch_en = (clk_cnt == cnt_t'(LATCH_CNT));

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            cols_left <= '0;
            c_addr    <= cfg_c.base;
        end
        else if (latch_en)
        begin
            cols_left <= CNT_BITS'(`MAT_SIZE);
            c_addr    <= cfg_c.base;
        end
        else if (cols_left != '0)
        begin
            cols_left <= cols_left - 1'b1;
            c_addr    <= c_addr + addr_t'(cfg_c.stride);
        end
    end

    // Column j of the grid gathers C[i][j] from every row i
    always_ff @(posedge clk)
    begin
        if (latch_en)
        begin
            for (int j = 0; j < `MAT_SIZE; j++)
                for (int i = 0; i < `MAT_SIZE; i++)
                    col_sr[j][i] <= results[i][j];
        end
        else if (cols_left != '0)
        begin
            for (int j = 0; j < `MAT_SIZE - 1; j++)
                col_sr[j] <= col_sr[j+1];
        end
    end

    assign c_data_out       = col_sr[0];
    assign c_data_available = (cols_left != '0);

endmodule

// ==== rtl/operand_feeder.sv ====
////////////////////////////////////////
// Issues MAT_SIZE strided reads in counts 0 to 3 and expects data one latency later
////////////////////////////////////////
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module operand_feeder (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start_mat_mul,
    input  systolic_pkg::cnt_t         clk_cnt,
    input  systolic_pkg::operand_cfg_t cfg,
    input  systolic_pkg::mask_t        lane_mask,
    input  systolic_pkg::mask_t        step_mask,
    input  systolic_pkg::lanes_t       mem_data,
    output systolic_pkg::addr_t        mem_addr,
    output systolic_pkg::lanes_t       skewed
);
    import systolic_pkg::*;

    localparam int STEP_BITS = `LOG2_MAT_SIZE + 1;

    logic                 mem_access;
    logic [STEP_BITS-1:0] access_cnt;
    logic [STEP_BITS-1:0] step_idx;
    logic                 step_valid;
    lanes_t               qualified;
    lanes_t               delay_q [`MAT_SIZE-1];

    ////////////////////////////////////////
    // Address burst
    ////////////////////////////////////////

    // The address rests one stride below base, so the first step lands on base
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || clk_cnt >= cnt_t'(`MAT_SIZE))
        begin
            mem_addr   <= cfg.base - addr_t'(cfg.stride);
            mem_access <= 1'b0;
        end
        else
        begin
            mem_addr   <= mem_addr + addr_t'(cfg.stride);
            mem_access <= 1'b1;
        end
    end

    // Counts responses; value LATENCY marks step 0 on the data bus
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !mem_access)
            access_cnt <= '0;
        else
            access_cnt <= access_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // Qualification and skew
    ////////////////////////////////////////

    assign step_idx   = access_cnt - STEP_BITS'(`MEM_ACCESS_LATENCY);
    assign step_valid = (access_cnt >= STEP_BITS'(`MEM_ACCESS_LATENCY))
                        && step_mask[step_idx[`LOG2_MAT_SIZE-1:0]];

    always_comb
    begin
        for (int i = 0; i < `MAT_SIZE; i++)
            qualified[i] = (step_valid && lane_mask[i]) ? mem_data[i] : '0;
    end

    // Delay stage s holds the qualified lanes from s+1 cycles ago
    always_ff @(posedge clk)
    begin
        delay_q[0] <= qualified;
        for (int s = 1; s < `MAT_SIZE - 1; s++)
            delay_q[s] <= delay_q[s-1];
    end

    // Lane i enters the mesh i cycles after its step was qualified
    always_comb
    begin
        skewed[0] = qualified[0];
        for (int i = 1; i < `MAT_SIZE; i++)
            skewed[i] = delay_q[i-1][i];
    end

endmodule

// ==== rtl/pe_array.sv ====
////////////////////////////////////////
// Edge inputs must already be skewed; pe_reset clears every accumulator
////////////////////////////////////////
`timescale 1ns/1ps
`include "systolic_cfg.svh"

module pe_array (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      pe_reset,
    input  systolic_pkg::lanes_t      a_edge,
    input  systolic_pkg::lanes_t      b_edge,
    output wire systolic_pkg::grid_t  results
);
    import systolic_pkg::*;

    logic pe_rst;

    // a_link[r][c] feeds PE (r,c) from the west, b_link[r][c] from the north
    wire elem_t a_link [`MAT_SIZE][`MAT_SIZE+1];
    wire elem_t b_link [`MAT_SIZE+1][`MAT_SIZE];

    assign pe_rst = reset | pe_reset;

    for (genvar r = 0; r < `MAT_SIZE; r++)
    begin : g_row
        assign a_link[r][0] = a_edge[r];
        assign b_link[0][r] = b_edge[r];

        for (genvar c = 0; c < `MAT_SIZE; c++)
        begin : g_col
            mac_pe pe_i (
                .clk   (clk),
                .reset (pe_rst),
                .in_a  (a_link[r][c]),
                .in_b  (b_link[r][c]),
                .out_a (a_link[r][c+1]),
                .out_b (b_link[r+1][c]),
                .acc   (results[r][c])
            );
        end
    end

endmodule

// ==== rtl/mac_pe.sv ====
////////////////////////////////////////
// Accumulator wraps at 8 bits; acc lags its operands by three cycles
////////////////////////////////////////
`timescale 1ns/1ps

module mac_pe (
    input  logic                clk,
    input  logic                reset,
    input  systolic_pkg::elem_t in_a,
    input  systolic_pkg::elem_t in_b,
    output systolic_pkg::elem_t out_a,
    output systolic_pkg::elem_t out_b,
    output systolic_pkg::elem_t acc
);
    import systolic_pkg::*;

    elem_t prod;

    // The neighbour registers double as the operand stage of the MAC
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_a <= '0;
            out_b <= '0;
        end
        else
        begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    // Product keeps only the low bits, so the sum wraps modulo 256
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prod <= '0;
            acc  <= '0;
        end
        else
        begin
            prod <= out_a * out_b;
            acc  <= acc + prod;
        end
    end

endmodule

// ==== rtl/systolic_pkg.sv ====
////////////////////////////////////////
// Types shared by the multiplier blocks, sized from the configuration macros
////////////////////////////////////////
`include "systolic_cfg.svh"

package systolic_pkg;

    // One operand or result element
    typedef logic [`DWIDTH-1:0] elem_t;

    // Lane i holds row i of an A column or C column, or column i of a B row
    typedef elem_t [`MAT_SIZE-1:0] lanes_t;

    // Row i, lane j holds C[i][j]
    typedef lanes_t [`MAT_SIZE-1:0] grid_t;

    typedef logic [`AWIDTH-1:0]       addr_t;
    typedef logic [`STRIDE_WIDTH-1:0] stride_t;
    typedef logic [`MAT_SIZE-1:0]     mask_t;
    typedef logic [`CNT_WIDTH-1:0]    cnt_t;

    // Placement of one matrix in memory, used for A, B and C
    typedef struct packed {
        addr_t   base;
        stride_t stride;
    } operand_cfg_t;

endpackage

// ==== include/systolic_cfg.svh ====
////////////////////////////////////////
// Fixed 4x4 configuration. MAT_SIZE and LOG2_MAT_SIZE must agree
////////////////////////////////////////
`ifndef SYSTOLIC_CFG_SVH
`define SYSTOLIC_CFG_SVH

// Element width of operands and wrapping accumulators
`define DWIDTH 8
// Memory address and address stride widths
`define AWIDTH 10
`define STRIDE_WIDTH 8

// Array dimension
`define MAT_SIZE 4
`define LOG2_MAT_SIZE 2

// Pipeline depth of the multiply-accumulate in each processing element
`define NUM_CYCLES_IN_MAC 3
// Read latency of the A and B memories
`define MEM_ACCESS_LATENCY 1
// Run cycle counter width
`define CNT_WIDTH 8

`endif
